// ==== trackball_pkg.sv ====
// pointer-side widths and types shared by the decoder, the axis counters and the top level
package trackball_pkg;

    // counter width of one axis, counts wrap modulo 2**CNT_W
    localparam int CNT_W    = 12;

    // number of quadrature axes, X and Y
    localparam int NUM_AXES = 2;

    // number of buttons: left, right, middle
    localparam int NUM_BTNS = 3;

    // one axis count
    typedef logic [CNT_W-1:0] count_t;

    // phase pair, A in the MSB and B in the LSB
    typedef logic [1:0] quad_t;

    // pressed buttons, active high
    // bit 2 is left, bit 1 is right, bit 0 is middle
    typedef logic [NUM_BTNS-1:0] buttons_t;

endpackage

// ==== apb_pkg.sv ====
// APB widths, register map and bus handler states used by the register block and testbench
package apb_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // register offsets
    localparam addr_t REG_X      = 8'h00; // X count, read only
    localparam addr_t REG_Y      = 8'h04; // Y count, read only
    localparam addr_t REG_STATUS = 8'h08; // flags and buttons, read only
    localparam addr_t REG_CTRL   = 8'h0C; // counter clears, write only

    // status bit positions
    localparam int STAT_CF  = 0; // sticky count flag
    localparam int STAT_SF  = 1; // any button pressed
    localparam int STAT_BTN = 2; // lsb of the 3-bit button field

    // control bit positions
    localparam int CTRL_CLR_X = 0;
    localparam int CTRL_CLR_Y = 1;

    // bus handler, one wait state per transfer
    typedef enum logic [1:0] {
        APB_IDLE, // waiting for a setup cycle
        APB_WAIT, // first access cycle, pready low
        APB_DONE  // second access cycle, pready high
    } apb_state_t;

endpackage

// ==== input_decode.sv ====
// synchronizes the quadrature pairs and buttons, then decodes each axis into step/up pulses
module input_decode
    import trackball_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  quad_t    x_in,
    input  quad_t    y_in,
    input  logic     leftn,
    input  logic     rightn,
    input  logic     middlen,
    output logic     x_step,
    output logic     x_up,
    output logic     y_step,
    output logic     y_up,
    output buttons_t buttons
);

    localparam int SYNC_W = 2 * NUM_AXES + NUM_BTNS;

    // phases idle at 00, buttons released (high)
    localparam logic [SYNC_W-1:0] SYNC_RST = {{(2 * NUM_AXES){1'b0}}, {NUM_BTNS{1'b1}}};

    logic [SYNC_W-1:0] sync_q [SYNC_STAGES];
    logic [SYNC_W-1:0] sync_out;
    quad_t             x_s, y_s;       // synchronized phases
    quad_t             x_prev, y_prev; // previous samples
    buttons_t          btn_n;
    logic [1:0]        x_dec, y_dec;   // {step, up}

    // x4 decode of one sample pair, only single-bit Gray moves count
    // A leads B: 00 -> 10 -> 11 -> 01 -> 00 counts up
    function automatic logic [1:0] quad_step(quad_t prev, quad_t cur);
        quad_t diff;
        diff = prev ^ cur;
        if (diff == 2'b01 || diff == 2'b10) begin
            return {1'b1, cur[1] ^ prev[0]};
        end
        return 2'b00; // no change or both phases moved
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= SYNC_RST;
            end
        end else begin
            sync_q[0] <= {x_in, y_in, leftn, rightn, middlen};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sync_out = sync_q[SYNC_STAGES-1];
    assign x_s      = sync_out[SYNC_W-1 -: 2];
    assign y_s      = sync_out[SYNC_W-3 -: 2];
    assign btn_n    = sync_out[NUM_BTNS-1:0];

    assign x_dec = quad_step(x_prev, x_s);
    assign y_dec = quad_step(y_prev, y_s);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_prev  <= '0;
            y_prev  <= '0;
            x_step  <= 1'b0;
            x_up    <= 1'b0;
            y_step  <= 1'b0;
            y_up    <= 1'b0;
            buttons <= '0;
        end else begin
            x_prev  <= x_s;
            y_prev  <= y_s;
            {x_step, x_up} <= x_dec;
            {y_step, y_up} <= y_dec;
            buttons <= ~btn_n; // active high from here on
        end
    end

endmodule

// ==== axis_counter.sv ====
// one 12-bit wrapping up/down axis counter with synchronous clear, used once per axis
module axis_counter
    import trackball_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   step,    // one count per pulse
    input  logic   up,      // direction, valid with step
    input  logic   clear,   // synchronous, wins over step
    output count_t count,
    output logic   changed  // one-cycle pulse per stepped update
);

    count_t next_count;

    // wraps naturally at CNT_W bits
    assign next_count = up ? count + count_t'(1) : count - count_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= '0;
            changed <= 1'b0;
        end else begin
            changed <= 1'b0;
            if (clear) begin
                count <= '0; // no changed pulse for a clear
            end else if (step) begin
                count   <= next_count;
                changed <= 1'b1;
            end
        end
    end

endmodule

// ==== trackball_regs.sv ====
// APB register block: count and status reads, control writes, sticky count flag and irq
module trackball_regs
    import trackball_pkg::*;
    import apb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  addr_t    paddr,
    input  data_t    pwdata,
    output data_t    prdata,
    output logic     pready,
    output logic     pslverr,
    input  count_t   x_count,
    input  count_t   y_count,
    input  logic     x_changed,
    input  logic     y_changed,
    input  buttons_t buttons,
    output logic     x_clear,
    output logic     y_clear,
    output logic     irq
);

    apb_state_t state;
    logic       count_flag;  // sticky, set by any counter step
    logic       flag_set;
    logic       switch_flag;
    logic       rd_ok;       // mapped read
    logic       wr_ok;       // mapped write
    logic       done_write;  // successful write completing now
    logic       status_rd;   // successful status read completing now
    data_t      rd_mux;
    data_t      status_word;

    assign flag_set    = x_changed | y_changed;
    assign switch_flag = |buttons;

    // a step landing right at the latch edge still reports as set
    always_comb begin
        status_word                              = '0;
        status_word[STAT_CF]                     = count_flag | flag_set;
        status_word[STAT_SF]                     = switch_flag;
        status_word[STAT_BTN +: NUM_BTNS]        = buttons;
    end

    always_comb begin
        case (paddr)
            REG_X:      rd_mux = data_t'(x_count);
            REG_Y:      rd_mux = data_t'(y_count);
            REG_STATUS: rd_mux = status_word;
            default:    rd_mux = '0;
        endcase
    end

    assign rd_ok = !pwrite && (paddr == REG_X || paddr == REG_Y || paddr == REG_STATUS);
    assign wr_ok = pwrite && (paddr == REG_CTRL);

    // pslverr already holds the decode result during APB_DONE
    assign done_write = (state == APB_DONE) && pwrite && !pslverr;
    assign status_rd  = (state == APB_DONE) && !pwrite && !pslverr && (paddr == REG_STATUS);

    assign pready = (state == APB_DONE);
    assign irq    = count_flag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= APB_IDLE;
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            case (state)
                APB_IDLE: begin
                    if (psel && !penable) begin
                        state <= APB_WAIT; // setup seen, access follows
                    end
                end
                APB_WAIT: begin
                    prdata  <= rd_ok ? rd_mux : '0;
                    pslverr <= !(rd_ok || wr_ok);
                    state   <= APB_DONE;
                end
                APB_DONE: begin
                    prdata  <= '0;
                    pslverr <= 1'b0;
                    state   <= APB_IDLE;
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // set wins over a read clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_flag <= 1'b0;
        end else if (flag_set) begin
            count_flag <= 1'b1;
        end else if (status_rd) begin
            count_flag <= 1'b0;
        end
    end

    // clear pulses land in the cycle after completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_clear <= 1'b0;
            y_clear <= 1'b0;
        end else begin
            x_clear <= done_write && pwdata[CTRL_CLR_X];
            y_clear <= done_write && pwdata[CTRL_CLR_Y];
        end
    end

endmodule

// ==== trackball_top.sv ====
// two-axis trackball counter with APB register port, top level that the testbench instantiates
module trackball_top
    import trackball_pkg::*;
    import apb_pkg::*;
#(
    parameter int SYNC_STAGES = 2 // 2 or 3
) (
    input  logic  clk,
    input  logic  rst,
    input  quad_t x_in,
    input  quad_t y_in,
    input  logic  leftn,
    input  logic  rightn,
    input  logic  middlen,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  data_t pwdata,
    output data_t prdata,
    output logic  pready,
    output logic  pslverr,
    output logic  irq
);

    logic     x_step, x_up, y_step, y_up;
    logic     x_clear, y_clear;
    logic     x_changed, y_changed;
    count_t   x_count, y_count;
    buttons_t buttons;

    input_decode #(
        .SYNC_STAGES (SYNC_STAGES)
    ) decode0 (
        .clk     (clk),
        .rst     (rst),
        .x_in    (x_in),
        .y_in    (y_in),
        .leftn   (leftn),
        .rightn  (rightn),
        .middlen (middlen),
        .x_step  (x_step),
        .x_up    (x_up),
        .y_step  (y_step),
        .y_up    (y_up),
        .buttons (buttons)
    );

    axis_counter x_cnt (
        .clk     (clk),
        .rst     (rst),
        .step    (x_step),
        .up      (x_up),
        .clear   (x_clear),
        .count   (x_count),
        .changed (x_changed)
    );

    axis_counter y_cnt (
        .clk     (clk),
        .rst     (rst),
        .step    (y_step),
        .up      (y_up),
        .clear   (y_clear),
        .count   (y_count),
        .changed (y_changed)
    );

    trackball_regs regs0 (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .x_count   (x_count),
        .y_count   (y_count),
        .x_changed (x_changed),
        .y_changed (y_changed),
        .buttons   (buttons),
        .x_clear   (x_clear),
        .y_clear   (y_clear),
        .irq       (irq)
    );

endmodule

// ==== tb_dial_gen.sv ====
// testbench dial emulator that moves one quadrature pair forward, back or by an invalid jump
module tb_dial_gen
    import trackball_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,   // one cycle wide, driven on the falling edge
    input  logic [1:0] kind,  // bit 1 invalid jump, else bit 0 selects backward
    output quad_t      phase
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       pending;
    logic [1:0] kind_q;

    // forward order has A leading B: 00 -> 10 -> 11 -> 01 -> 00
    function automatic quad_t next_phase(quad_t cur, logic [1:0] how);
        quad_t nxt;
        if (how[1]) begin
            nxt = ~cur; // both phases in one sample
        end else if (!how[0]) begin
            case (cur)
                2'b00:   nxt = 2'b10;
                2'b10:   nxt = 2'b11;
                2'b11:   nxt = 2'b01;
                default: nxt = 2'b00;
            endcase
        end else begin
            case (cur)
                2'b00:   nxt = 2'b01;
                2'b01:   nxt = 2'b11;
                2'b11:   nxt = 2'b10;
                default: nxt = 2'b00;
            endcase
        end
        return nxt;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            kind_q  <= 2'b00;
        end else begin
            pending <= req; // captured here, applied on the next falling edge
            kind_q  <= kind;
        end
    end

    always @(negedge clk or posedge rst) begin
        if (rst) begin
            phase <= 2'b00;
        end else if (pending) begin
            phase <= next_phase(phase, kind_q);
        end
    end

endmodule

// ==== tb_trackball.sv ====
// testbench top for the trackball counter, drives dials, buttons and APB and checks a model
module tb_trackball
    import trackball_pkg::*;
    import apb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         RST_CYCLES = 16;
    localparam int         WAIT_LIMIT = 50; // cycles before a wait gives up
    localparam int         SETTLE     = 8;  // phase move to stable count
    localparam logic [1:0] MOVE_FWD   = 2'd0;
    localparam logic [1:0] MOVE_BACK  = 2'd1;
    localparam logic [1:0] MOVE_BAD   = 2'd2;

    logic       clk, rst;
    quad_t      x_in, y_in;
    logic       leftn, rightn, middlen;
    logic       psel, penable, pwrite;
    addr_t      paddr;
    data_t      pwdata, prdata;
    logic       pready, pslverr, irq;
    logic       x_req, y_req;
    logic [1:0] x_kind, y_kind;
    int         exp_x, exp_y;    // model counts, modulo 4096
    logic       exp_flag;        // model sticky flag
    logic [2:0] pressed;         // left, right, middle
    logic [2:0] btn_sets [6] = '{3'b100, 3'b010, 3'b001, 3'b101, 3'b111, 3'b000};
    string      test_name;
    int         checks, errors, errors_before, tests_run, tests_bad, n;
    int unsigned seed_val;
    logic       timed_out = 1'b0;

    trackball_top dut0 (.*);

    tb_dial_gen x_gen (.clk(clk), .rst(rst), .req(x_req), .kind(x_kind), .phase(x_in));
    tb_dial_gen y_gen (.clk(clk), .rst(rst), .req(y_req), .kind(y_kind), .phase(y_in));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ends the run once any wait has run out of time
    initial begin
        wait (timed_out);
        $display("test failed");
        $finish;
    end

    function automatic data_t expected_status(input logic flag, input logic [2:0] btns);
        return {27'd0, btns, |btns, flag};
    endfunction

    task automatic give_up(input string why);
        $display("%s", why);
        timed_out = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic check_value(input string what, input data_t expected, input data_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error %s, %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_before) begin
            $display("%-16s ok", test_name);
        end else begin
            $display("%-16s FAILED, %0d errors", test_name, errors - errors_before);
            tests_bad++;
        end
    endtask

    task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err);
        int waited;
        @(negedge clk);
        psel    = 1'b1; // setup cycle
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        while (!pready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            give_up($sformatf("pready never came within %0d cycles, address %h",
                              WAIT_LIMIT, addr));
        end
        rdata   = prdata;
        err     = pslverr;
        @(negedge clk); // held through the completing edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        check_value("wait states", data_t'(1), data_t'(waited));
    endtask

    task automatic read_expect(input string what, input addr_t addr, input data_t expected);
        data_t rdata;
        logic  err;
        bus_access(1'b0, addr, '0, rdata, err);
        check_value({what, " data"}, expected, rdata);
        check_value({what, " pslverr"}, '0, data_t'(err));
    endtask

    task automatic read_status();
        read_expect("status", REG_STATUS, expected_status(exp_flag, pressed));
        exp_flag = 1'b0; // returned the old value, now cleared
    endtask

    task automatic expect_error(input string what, input logic wr, input addr_t addr);
        data_t rdata;
        logic  err;
        bus_access(wr, addr, 32'hffff_ffff, rdata, err);
        check_value({what, " pslverr"}, data_t'(1), data_t'(err));
    endtask

    task automatic write_ctrl(input data_t value);
        data_t rdata;
        logic  err;
        bus_access(1'b1, REG_CTRL, value, rdata, err);
        check_value("control pslverr", '0, data_t'(err));
        if (value[0]) begin
            exp_x = 0;
        end
        if (value[1]) begin
            exp_y = 0;
        end
    endtask

    task automatic dial_move(input logic on_y, input logic [1:0] how);
        int delta;
        delta = (how == MOVE_FWD) ? 1 : 4095; // minus one modulo 4096
        @(negedge clk);
        if (on_y) begin
            y_req  = 1'b1;
            y_kind = how;
        end else begin
            x_req  = 1'b1;
            x_kind = how;
        end
        @(negedge clk);
        x_req = 1'b0;
        y_req = 1'b0;
        if (how != MOVE_BAD) begin
            exp_flag = 1'b1;
            if (on_y) begin
                exp_y = (exp_y + delta) % 4096;
            end else begin
                exp_x = (exp_x + delta) % 4096;
            end
        end
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (irq !== level && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (irq !== level) begin
            give_up($sformatf("irq did not reach %0b within %0d cycles", level, WAIT_LIMIT));
        end
    endtask

    task automatic set_buttons(input logic [2:0] p);
        @(negedge clk);
        leftn   = ~p[2];
        rightn  = ~p[1];
        middlen = ~p[0];
        pressed = p;
        repeat (SETTLE) @(negedge clk); // through the synchronizer
    endtask

    task automatic check_counts_and_irq();
        read_expect("x count", REG_X, data_t'(exp_x));
        read_expect("y count", REG_Y, data_t'(exp_y));
        check_value("irq", data_t'(exp_flag), data_t'(irq));
    endtask

    initial begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        leftn    = 1'b1;
        rightn   = 1'b1;
        middlen  = 1'b1;
        x_req    = 1'b0;
        y_req    = 1'b0;
        x_kind   = MOVE_FWD;
        y_kind   = MOVE_FWD;
        exp_x    = 0;
        exp_y    = 0;
        exp_flag = 1'b0;
        pressed  = '0;
        checks   = 0;
        errors   = 0;
        tests_run = 0;
        tests_bad = 0;
        seed_val = $urandom(32'h763c_c4bc);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        check_value("pready idle", '0, data_t'(pready));
        check_value("pslverr idle", '0, data_t'(pslverr));
        check_value("prdata idle", '0, prdata);
        check_counts_and_irq();
        read_status();
        end_test();

        start_test("count_up");
        n = $urandom_range(40, 1);
        repeat (n) dial_move(1'b0, MOVE_FWD);
        repeat (SETTLE) @(negedge clk);
        wait_irq(1'b1);
        check_counts_and_irq();
        end_test();

        start_test("count_down_wrap");
        n = $urandom_range(40, 1);
        repeat (n) dial_move(1'b1, MOVE_BACK);
        repeat (SETTLE) @(negedge clk);
        check_counts_and_irq();
        end_test();

        start_test("invalid_step");
        read_status(); // drop the flag left by earlier motion
        @(negedge clk);
        dial_move(1'b0, MOVE_BAD);
        repeat (SETTLE) @(negedge clk);
        check_counts_and_irq();
        read_status();
        dial_move(1'b0, MOVE_FWD); // decode resumes from the new phase
        repeat (SETTLE) @(negedge clk);
        check_counts_and_irq();
        end_test();

        start_test("flags_buttons");
        dial_move(1'b1, MOVE_FWD);
        repeat (SETTLE) @(negedge clk);
        read_status();
        read_status();
        @(negedge clk);
        check_value("irq", data_t'(exp_flag), data_t'(irq));
        foreach (btn_sets[i]) begin
            set_buttons(btn_sets[i]);
            read_status();
        end
        end_test();

        start_test("control_errors");
        dial_move(1'b0, MOVE_FWD);
        dial_move(1'b1, MOVE_FWD);
        repeat (SETTLE) @(negedge clk);
        expect_error("unmapped read", 1'b0, 8'h10);
        expect_error("x write", 1'b1, REG_X);
        expect_error("control read", 1'b0, REG_CTRL);
        check_counts_and_irq();
        read_status(); // error reads must not have cleared it
        write_ctrl(32'd3);
        @(negedge clk);
        check_counts_and_irq();
        read_status();
        end_test();

        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
trackball_pkg.sv
apb_pkg.sv
input_decode.sv
axis_counter.sv
trackball_regs.sv
trackball_top.sv
tb_dial_gen.sv
tb_trackball.sv

// ==== Makefile ====
# Verilator build and run of the trackball testbench

VERILATOR ?= verilator
TOP       ?= tb_trackball
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
